//--- verilog.f
src/synthPkg.sv
src/fmCfgPkg.sv
src/fmConfigFsm.sv
src/voicePhasor.sv
src/waveShaper.sv
src/fmMixer.sv
src/i2sTransmitter.sv
src/fpgaSynth.sv
bench/fpgaSynth_checker.sv
bench/synthTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the synthesizer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module synthTb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOutput=$(./obj_dir/VsynthTb)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi

if echo "$simOutput" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

//--- bench/synthTb.sv
`timescale 1ns/10ps

module synthTb;
	import synthPkg::*;
	import fmCfgPkg::*;

	localparam int FmShift = 6;
	// Codec timing, in system clocks and bits
	localparam int SclkHalf = 8;
	localparam int SlotBits = 32;
	localparam int PressLimit = 20;

	logic       MAX10_CLK2_50;
	logic       rstN;
	logic       keyContinueN;
	switches_t  sw;
	leds_t      ledr;
	phaseInc_t  phaseIncs [NumVoices];
	amplitude_t amplitude;
	logic       sclk;
	logic       lrclk;
	logic       sdOut;

	// Reference model of the configuration and voices
	cfgState_t   tbState;
	waveSel_t    mWave [NumVoices];
	fmEnable_t   mEnable [NumVoices];
	fmWeight_t   mWeight [NumVoices][NumVoices];
	phase_t      mPhase [NumVoices];
	logic [15:0] lfsrState;
	int          errorCount;
	int          errorsBefore;
	int          testCount;
	int          badTests;

	fpgaSynth #(
		.FmShift(FmShift)
	) i_dut (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.keyContinueN(keyContinueN),
		.sw(sw),
		.ledr(ledr),
		.phaseIncs(phaseIncs),
		.amplitude(amplitude),
		.sclk(sclk),
		.lrclk(lrclk),
		.sdOut(sdOut)
	);

	// Unused checker inputs tied to values that always hold
	bind fmConfigFsm fpgaSynthChecker fsmChecks (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.state(state),
		.ledr(ledr),
		.frameStart(1'b0)
	);
	bind i2sTransmitter fpgaSynthChecker i2sChecks (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.state(2'b00),
		.ledr(10'h000),
		.frameStart(frameStart)
	);

	always #10 MAX10_CLK2_50 = ~MAX10_CLK2_50;

	// ==========================================================
	// Compare tasks and reference rules
	// ==========================================================

	task automatic checkLeds(input string name, input leds_t got, input leds_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkSample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Mirror masks per state
	function automatic leds_t ledPattern(input cfgState_t st, input switches_t value);
		case (st)
			cfgLoadWaves:   return value & 10'h3C3;
			cfgLoadEnables: return value & 10'h3FC;
			cfgLoadWeights: return value & 10'h0FF;
			default:        return '0;
		endcase
	endfunction

	function automatic cfgState_t nextState(input cfgState_t st);
		case (st)
			cfgRun:         return cfgLoadWaves;
			cfgLoadWaves:   return cfgLoadEnables;
			cfgLoadEnables: return cfgLoadWeights;
			default:        return cfgRun;
		endcase
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per switch bit
	task automatic drawSwitches(output switches_t value);
		for (int i = 0; i < 10; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value[i] = lfsrState[0];
		end
	endtask

	// Loads of the current state for one switch value
	task automatic modelLoad(input switches_t value);
		for (int v = 0; v < NumVoices; v++) begin
			if (value[9 - v] && tbState == cfgLoadWaves)
				mWave[v] = waveSel_t'(value[1:0]);
			if (value[9 - v] && tbState == cfgLoadEnables)
				mEnable[v] = value[5:2];
			for (int src = 0; src < NumVoices; src++) begin
				if (tbState == cfgLoadWeights && mEnable[v][src])
					mWeight[v][src] = value[7:0];
			end
		end
	endtask

	// Waveform value from the top 16 phase bits
	function automatic longint shapeRef(input phase_t ph, input waveSel_t w);
		longint p;
		p = longint'(ph[31:16]);
		case (w)
			waveSaw:      return p - 32768;
			waveSquare:   return ph[31] ? -32767 : 32767;
			waveTriangle: return (p < 32768) ? -32768 + 2 * p : -32768 + 2 * (65535 - p);
			default:      return 0;
		endcase
	endfunction

	// Heard sample for this frame, then one phase step with FM
	task automatic modelFrame(output sample_t heard);
		longint smp [NumVoices];
		longint acc;
		longint fmSum;
		acc = 0;
		for (int v = 0; v < NumVoices; v++) begin
			smp[v] = shapeRef(mPhase[v], mWave[v]);
			acc += smp[v];
		end
		acc = (acc * longint'(amplitude)) >>> 18;
		heard = sample_t'(acc);
		for (int v = 0; v < NumVoices; v++) begin
			fmSum = 0;
			for (int src = 0; src < NumVoices; src++) begin
				fmSum += longint'(mWeight[v][src]) * smp[src];
			end
			mPhase[v] = mPhase[v] + phaseIncs[v] + phase_t'(fmSum >>> FmShift);
		end
	endtask

	// ==========================================================
	// Stimulus: button, switches, codec
	// ==========================================================

	task automatic setSwitches(input switches_t value);
		@(posedge MAX10_CLK2_50);
		#2;
		sw = value;
		// LEDs follow one cycle later
		@(posedge MAX10_CLK2_50);
		#1;
		checkLeds("ledr", ledr, ledPattern(tbState, value));
		modelLoad(value);
	endtask

	task automatic setAmplitude(input amplitude_t value);
		@(posedge MAX10_CLK2_50);
		#2;
		amplitude = value;
	endtask

	task automatic pressContinue();
		leds_t want;
		bit    seen;
		tbState = nextState(tbState);
		want = ledPattern(tbState, sw);
		seen = 1'b0;
		@(posedge MAX10_CLK2_50);
		#2;
		keyContinueN = 1'b0;
		// Held until the new state shows on the LEDs
		for (int i = 0; i < PressLimit && !seen; i++) begin
			@(posedge MAX10_CLK2_50);
			#1;
			seen = (ledr == want);
		end
		if (!seen) begin
			errorCount++;
			$display("LEDs never showed the next state within %0d cycles of a button press",
				PressLimit);
		end
		repeat (4) @(posedge MAX10_CLK2_50);
		#2;
		keyContinueN = 1'b1;
		repeat (4) @(posedge MAX10_CLK2_50);
		#1;
		checkLeds("ledr after press", ledr, want);
		modelLoad(sw);
	endtask

	// One channel slot, lrclk changes with the first falling sclk
	task automatic codecSlot(input logic level, output i2sWord_t word, output int strobes);
		i2sWord_t bits;
		bits = '0;
		strobes = 0;
		for (int j = 0; j < SlotBits; j++) begin
			@(posedge MAX10_CLK2_50);
			#2;
			sclk = 1'b0;
			if (j == 0)
				lrclk = level;
			for (int k = 0; k < SclkHalf; k++) begin
				@(posedge MAX10_CLK2_50);
				#1;
				if (i_dut.frameStart)
					strobes++;
			end
			#1;
			sclk = 1'b1;
			// First rise still carries the previous word's last bit
			if (j > 0)
				bits[SlotBits - j] = sdOut;
			repeat (SclkHalf - 1) @(posedge MAX10_CLK2_50);
		end
		// Held until the next slot's first rise
		#1;
		bits[0] = sdOut;
		word = bits;
	endtask

	task automatic runFrames(input int count);
		i2sWord_t leftWord;
		i2sWord_t rightWord;
		sample_t  expected;
		int       nLeft;
		int       nRight;
		for (int f = 0; f < count; f++) begin
			codecSlot(1'b0, leftWord, nLeft);
			codecSlot(1'b1, rightWord, nRight);
			if (nLeft != 1 || nRight != 0) begin
				errorCount++;
				$display("Frame strobe seen %0d times in the frame ending at %0t",
					nLeft + nRight, $time);
			end
			modelFrame(expected);
			checkSample("left sample", leftWord[31:16], expected);
			checkSample("left low half", leftWord[15:0], '0);
			checkSample("right sample", rightWord[31:16], expected);
			checkSample("right low half", rightWord[15:0], '0);
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("test %0d, %s: ok", testCount, name);
		end else begin
			badTests++;
			$display("test %0d, %s: %0d errors", testCount, name, errorCount - errorsBefore);
		end
		errorsBefore = errorCount;
	endtask

	// ==========================================================
	// Directed tests
	// ==========================================================

	// All voices off, so the first frame is silent
	task automatic testReset();
		checkLeds("ledr after reset", ledr, '0);
		runFrames(1);
	endtask

	task automatic testConfigCycle();
		switches_t value;
		for (int i = 0; i < 4; i++) begin
			drawSwitches(value);
			setSwitches(value);
			pressContinue();
			drawSwitches(value);
			setSwitches(value);
		end
		checkLeds("ledr back in run", ledr, '0);
	endtask

	task automatic testWaves();
		setAmplitude(16'hFFFF);
		setSwitches('0);
		pressContinue();
		// Voice 0 square, 1 saw, 2 triangle, 3 saw
		setSwitches(10'h201);
		setSwitches(10'h100);
		setSwitches(10'h082);
		setSwitches(10'h040);
		pressContinue();
		// Every route on, then every weight zero
		setSwitches(10'h3FC);
		pressContinue();
		setSwitches(10'h000);
		pressContinue();
		runFrames(8);
	endtask

	task automatic testFm();
		pressContinue();
		pressContinue();
		// Clear all routes, then voice 1 hears voice 0
		setSwitches(10'h3C0);
		setSwitches(10'h104);
		pressContinue();
		setSwitches(10'h0C0);
		pressContinue();
		setSwitches('0);
		runFrames(8);
	endtask

	task automatic testAmplitude();
		setAmplitude(16'h8000);
		runFrames(4);
		// Every voice off, routes cleared on the way through
		pressContinue();
		setSwitches(10'h3C3);
		pressContinue();
		pressContinue();
		pressContinue();
		setSwitches('0);
		runFrames(2);
	endtask

	// ==========================================================
	// Main sequence and watchdog
	// ==========================================================

	initial begin
		MAX10_CLK2_50 = 1'b0;
		rstN = 1'b0;
		keyContinueN = 1'b1;
		sw = '0;
		amplitude = '0;
		// Codec idles at the end of a right slot
		sclk = 1'b1;
		lrclk = 1'b1;
		phaseIncs[0] = 32'h0A3D_70A4;
		phaseIncs[1] = 32'h1111_1111;
		phaseIncs[2] = 32'h0765_4321;
		phaseIncs[3] = 32'h1F00_0000;
		tbState = cfgRun;
		for (int v = 0; v < NumVoices; v++) begin
			mWave[v] = waveOff;
			mEnable[v] = '0;
			mPhase[v] = '0;
			for (int src = 0; src < NumVoices; src++) begin
				mWeight[v][src] = '0;
			end
		end
		lfsrState = 16'd99;
		errorCount = 0;
		errorsBefore = 0;
		testCount = 0;
		badTests = 0;
		repeat (2) @(posedge MAX10_CLK2_50);
		#2;
		rstN = 1'b1;

		testReset();
		endTest("reset state and silent frame");
		testConfigCycle();
		endTest("configuration cycle and LED mirror");
		testWaves();
		endTest("waveforms at full amplitude");
		testFm();
		endTest("FM from voice 0 to voice 1");
		testAmplitude();
		endTest("half amplitude and all voices off");

		$display("%0d tests, %0d with errors, %0d check errors", testCount, badTests, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Whole run is well under 1 ms
	initial begin
		#2_000_000;
		$display("Run exceeded its time limit");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- bench/fpgaSynth_checker.sv
`timescale 1ns/10ps

module fpgaSynthChecker (
	input logic            MAX10_CLK2_50,
	input logic            rstN,
	input logic [1:0]      state,
	input fmCfgPkg::leds_t ledr,
	input logic            frameStart
);
	import fmCfgPkg::*;

	// State only steps to the next configuration state in sequence
	// Run follows weights by wrapping
	stateLegal: assert property (@(posedge MAX10_CLK2_50) disable iff (!rstN)
		(state != $past(state)) |-> (state == $past(state) + 2'd1))
		else $error("configuration state %b entered out of sequence", state);

	// Frame strobe is a single-cycle pulse
	strobeWidth: assert property (@(posedge MAX10_CLK2_50) disable iff (!rstN)
		frameStart |=> !frameStart)
		else $error("frame strobe held longer than one cycle");

	// LEDs dark while running
	ledsInRun: assert property (@(posedge MAX10_CLK2_50) disable iff (!rstN)
		(state == cfgRun) |-> (ledr == '0))
		else $error("LEDs lit in run state: %h", ledr);

endmodule

//--- src/fpgaSynth.sv
`timescale 1ns/10ps

module fpgaSynth #(
	parameter int FmShift = 6
) (
	input  logic                 MAX10_CLK2_50,
	input  logic                 rstN,
	input  logic                 keyContinueN,
	input  fmCfgPkg::switches_t  sw,
	output fmCfgPkg::leds_t      ledr,
	input  synthPkg::phaseInc_t  phaseIncs [synthPkg::NumVoices],
	input  synthPkg::amplitude_t amplitude,
	input  logic                 sclk,
	input  logic                 lrclk,
	output logic                 sdOut
);
	import synthPkg::*;
	import fmCfgPkg::*;

	logic                    frameStart;
	waveSel_t                waveSels [NumVoices];
	fmWeight_t               fmWeights [NumVoices][NumVoices];
	phase_t                  phases [NumVoices];
	sample_t                 samples [NumVoices];
	logic signed [FmSumWidth-1:0] fmSums [NumVoices];
	sample_t                 mixSample;

	// ==========================================================
	// Configuration from switches and button
	// ==========================================================

	fmConfigFsm cfgFsm (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.keyContinueN(keyContinueN),
		.sw(sw),
		.ledr(ledr),
		.waveSels(waveSels),
		.fmWeights(fmWeights)
	);

	// ==========================================================
	// Voice pipeline, phase then shape then mix
	// ==========================================================

	voicePhasor #(
		.FmShift(FmShift)
	) phasor (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.frameStart(frameStart),
		.phaseIncs(phaseIncs),
		.fmSums(fmSums),
		.phases(phases)
	);

	waveShaper shaper (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.phases(phases),
		.waveSels(waveSels),
		.samples(samples)
	);

	// FM sums feed back to the phasor for the next frame
	fmMixer mixer (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.samples(samples),
		.fmWeights(fmWeights),
		.amplitude(amplitude),
		.fmSums(fmSums),
		.mixSample(mixSample)
	);

	// Codec clocks pace the whole pipeline
	i2sTransmitter i2sTx (
		.MAX10_CLK2_50(MAX10_CLK2_50),
		.rstN(rstN),
		.sclk(sclk),
		.lrclk(lrclk),
		.mixSample(mixSample),
		.frameStart(frameStart),
		.sdOut(sdOut)
	);

endmodule

//--- src/i2sTransmitter.sv
`timescale 1ns/10ps

module i2sTransmitter (
	input  logic              MAX10_CLK2_50,
	input  logic              rstN,
	input  logic              sclk,
	input  logic              lrclk,
	input  synthPkg::sample_t mixSample,
	output logic              frameStart,
	output logic              sdOut
);
	import synthPkg::*;

	// Bits 1:0 synchronize, bit 2 is the previous synced value
	logic [2:0] sclkSync;
	logic [2:0] lrclkSync;
	logic       sclkFall;
	logic       lrclkChange;
	logic       lrclkFall;
	sample_t    heldSample;
	i2sWord_t   shiftReg;

	// ==========================================================
	// Codec clock synchronizers
	// ==========================================================

	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			sclkSync  <= '0;
			lrclkSync <= '0;
		end else begin
			sclkSync  <= {sclkSync[1:0], sclk};
			lrclkSync <= {lrclkSync[1:0], lrclk};
		end
	end

	assign sclkFall    = sclkSync[2] & ~sclkSync[1];
	assign lrclkChange = lrclkSync[2] ^ lrclkSync[1];
	// Low lrclk is the left channel
	assign lrclkFall   = lrclkSync[2] & ~lrclkSync[1];

	// ==========================================================
	// Word load and serial shift
	// ==========================================================

	// Reload wins over a coincident sclk fall
	// so the MSB goes out on the next fall, one bit late as I2S wants
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			frameStart <= 1'b0;
			heldSample <= '0;
			shiftReg   <= '0;
			sdOut      <= 1'b0;
		end else begin
			frameStart <= lrclkFall;
			if (lrclkChange) begin
				if (lrclkFall) begin
					// Same sample kept for the right slot
					heldSample <= mixSample;
					shiftReg   <= {mixSample, 16'h0000};
				end else begin
					shiftReg <= {heldSample, 16'h0000};
				end
			end else if (sclkFall) begin
				sdOut    <= shiftReg[31];
				shiftReg <= {shiftReg[30:0], 1'b0};
			end
		end
	end

endmodule

//--- src/fmMixer.sv
`timescale 1ns/10ps

module fmMixer (
	input  logic                 MAX10_CLK2_50,
	input  logic                 rstN,
	input  synthPkg::sample_t    samples [synthPkg::NumVoices],
	input  fmCfgPkg::fmWeight_t  fmWeights [synthPkg::NumVoices][synthPkg::NumVoices],
	input  synthPkg::amplitude_t amplitude,
	output logic signed [synthPkg::FmSumWidth-1:0] fmSums [synthPkg::NumVoices],
	output synthPkg::sample_t    mixSample
);
	import synthPkg::*;

	// Brings 4 x 16-bit samples times 16-bit volume back to 16 bits
	localparam int MixShift = 18;

	logic signed [FmSumWidth-1:0] sumNext [NumVoices];
	logic signed [17:0]           voiceSum;
	logic signed [34:0]           mixProd;

	// Weighted FM sums, dest v from sources s
	// Weights are unsigned so pad a zero sign bit
	always_comb begin
		for (int v = 0; v < NumVoices; v++) begin
			sumNext[v] = '0;
			for (int s = 0; s < NumVoices; s++) begin
				sumNext[v] = sumNext[v] + $signed({1'b0, fmWeights[v][s]}) * samples[s];
			end
		end
	end

	// Plain voice sum scaled by master volume
	always_comb begin
		voiceSum = '0;
		for (int s = 0; s < NumVoices; s++) begin
			voiceSum = voiceSum + samples[s];
		end
		mixProd = voiceSum * $signed({1'b0, amplitude});
	end

	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			for (int v = 0; v < NumVoices; v++) begin
				fmSums[v] <= '0;
			end
			mixSample <= '0;
		end else begin
			fmSums    <= sumNext;
			// Result fits 16 bits for any input
			mixSample <= sample_t'(mixProd >>> MixShift);
		end
	end

endmodule

//--- src/waveShaper.sv
`timescale 1ns/10ps

module waveShaper (
	input  logic               MAX10_CLK2_50,
	input  logic               rstN,
	input  synthPkg::phase_t   phases [synthPkg::NumVoices],
	input  fmCfgPkg::waveSel_t waveSels [synthPkg::NumVoices],
	output synthPkg::sample_t  samples [synthPkg::NumVoices]
);
	import synthPkg::*;
	import fmCfgPkg::*;

	// Waveform value from the top 16 phase bits
	function automatic sample_t shape(input phase_t phase, input waveSel_t sel);
		logic [15:0] p;
		logic [15:0] q;
		sample_t     y;
		p = phase[31:16];
		// Second half mirrored for the falling slope
		q = p[15] ? ~p : p;
		case (sel)
			// Offset binary to two's complement
			waveSaw:      y = sample_t'({~p[15], p[14:0]});
			waveSquare:   y = p[15] ? -16'sd32767 : 16'sd32767;
			// -32768 plus 2q
			waveTriangle: y = sample_t'({~q[14], q[13:0], 1'b0});
			default:      y = '0;
		endcase
		return y;
	endfunction

	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			for (int v = 0; v < NumVoices; v++) begin
				samples[v] <= '0;
			end
		end else begin
			for (int v = 0; v < NumVoices; v++) begin
				samples[v] <= shape(phases[v], waveSels[v]);
			end
		end
	end

endmodule

//--- src/voicePhasor.sv
`timescale 1ns/10ps

module voicePhasor #(
	parameter int FmShift = 6
) (
	input  logic                MAX10_CLK2_50,
	input  logic                rstN,
	input  logic                frameStart,
	input  synthPkg::phaseInc_t phaseIncs [synthPkg::NumVoices],
	input  logic signed [synthPkg::FmSumWidth-1:0] fmSums [synthPkg::NumVoices],
	output synthPkg::phase_t    phases [synthPkg::NumVoices]
);
	import synthPkg::*;

	fmOffset_t fmOffsets [NumVoices];

	// Scale raw weighted sums down to a phase offset
	// Sign extend first so the shift keeps the sign
	always_comb begin
		for (int v = 0; v < NumVoices; v++) begin
			fmOffsets[v] = fmOffset_t'(fmSums[v]) >>> FmShift;
		end
	end

	// One step per audio frame
	// Wraps modulo 2^32 by width
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			for (int v = 0; v < NumVoices; v++) begin
				phases[v] <= '0;
			end
		end else if (frameStart) begin
			for (int v = 0; v < NumVoices; v++) begin
				// Negative offset adds as two's complement
				phases[v] <= phases[v] + phaseIncs[v] + phase_t'(fmOffsets[v]);
			end
		end
	end

endmodule

//--- src/fmConfigFsm.sv
`timescale 1ns/10ps

module fmConfigFsm (
	input  logic                MAX10_CLK2_50,
	input  logic                rstN,
	input  logic                keyContinueN,
	input  fmCfgPkg::switches_t sw,
	output fmCfgPkg::leds_t     ledr,
	output fmCfgPkg::waveSel_t  waveSels [synthPkg::NumVoices],
	output fmCfgPkg::fmWeight_t fmWeights [synthPkg::NumVoices][synthPkg::NumVoices]
);
	import synthPkg::*;
	import fmCfgPkg::*;

	logic [1:0] keySync;
	logic       keyPrev;
	logic       keyStep;
	cfgState_t  state;
	cfgState_t  stateNext;
	leds_t      ledNext;
	fmEnable_t  fmEnables [NumVoices];

	// ==========================================================
	// Button synchronizer and press detect
	// ==========================================================

	// Button idles high
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			keySync <= 2'b11;
			keyPrev <= 1'b1;
		end else begin
			keySync <= {keySync[0], keyContinueN};
			keyPrev <= keySync[1];
		end
	end

	// One pulse per press
	assign keyStep = keyPrev & ~keySync[1];

	// ==========================================================
	// State sequence and LED mirror
	// ==========================================================

	always_comb begin
		stateNext = state;
		if (keyStep) begin
			case (state)
				cfgRun:         stateNext = cfgLoadWaves;
				cfgLoadWaves:   stateNext = cfgLoadEnables;
				cfgLoadEnables: stateNext = cfgLoadWeights;
				default:        stateNext = cfgRun;
			endcase
		end
	end

	// Pattern of the state being entered, so LEDs and state move together
	always_comb begin
		case (stateNext)
			cfgLoadWaves:   ledNext = {sw[9:6], 4'b0000, sw[1:0]};
			cfgLoadEnables: ledNext = {sw[9:2], 2'b00};
			cfgLoadWeights: ledNext = {2'b00, sw[7:0]};
			default:        ledNext = '0;
		endcase
	end

	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			state <= cfgRun;
			ledr  <= '0;
		end else begin
			state <= stateNext;
			ledr  <= ledNext;
		end
	end

	// Config loads, voice v selected by sw[9-v]
	always_ff @(posedge MAX10_CLK2_50 or negedge rstN) begin
		if (!rstN) begin
			for (int v = 0; v < NumVoices; v++) begin
				waveSels[v]  <= waveOff;
				fmEnables[v] <= '0;
				for (int s = 0; s < NumVoices; s++) begin
					fmWeights[v][s] <= '0;
				end
			end
		end else begin
			for (int v = 0; v < NumVoices; v++) begin
				if (state == cfgLoadWaves && sw[9 - v]) begin
					waveSels[v] <= waveSel_t'(sw[1:0]);
				end
				// Source s enabled by sw[2+s]
				if (state == cfgLoadEnables && sw[9 - v]) begin
					fmEnables[v] <= sw[5:2];
				end
				// Every enabled route takes the same weight
				for (int s = 0; s < NumVoices; s++) begin
					if (state == cfgLoadWeights && fmEnables[v][s]) begin
						fmWeights[v][s] <= sw[7:0];
					end
				end
			end
		end
	end

endmodule

//--- src/fmCfgPkg.sv
package fmCfgPkg;

	// Configuration steps, advanced by the continue button
	typedef enum logic [1:0] {
		cfgRun,
		cfgLoadWaves,
		cfgLoadEnables,
		cfgLoadWeights
	} cfgState_t;

	// Waveform codes as set on sw[1:0]
	typedef enum logic [1:0] {
		waveSaw,
		waveSquare,
		waveTriangle,
		waveOff
	} waveSel_t;

	typedef logic [7:0] fmWeight_t;
	// One bit per modulating source voice
	typedef logic [3:0] fmEnable_t;

	typedef logic [9:0] switches_t;
	typedef logic [9:0] leds_t;

endpackage

//--- src/synthPkg.sv
package synthPkg;

	// Voice count, fixed by the switch layout
	localparam int NumVoices = 4;

	// Width of a raw weighted FM sum
	// 8-bit weight times 16-bit sample needs 24 bits, four of them need 26
	localparam int FmSumWidth = 26;

	// Phase accumulator and its per-frame step
	typedef logic [31:0] phase_t;
	typedef logic [31:0] phaseInc_t;

	// One voice sample or the mixed output
	typedef logic signed [15:0] sample_t;

	// Phase offset contributed by FM
	typedef logic signed [31:0] fmOffset_t;

	// Master volume, unsigned
	typedef logic [15:0] amplitude_t;

	// I2S slot word with the sample in the upper half
	typedef logic [31:0] i2sWord_t;

endpackage
